/* logic/lsu_pkg.sv */
package lsu_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int BUS_WIDTH = 64;
	localparam int STRB_WIDTH = BUS_WIDTH / 8;

	// axi response code for a clean beat
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// ------------------------------
	// operations
	// ------------------------------
	// loads first, stores last
	typedef enum logic [2:0] {
		op_lb  = 3'd0,
		op_lbu = 3'd1,
		op_lh  = 3'd2,
		op_lhu = 3'd3,
		op_lw  = 3'd4,
		op_sb  = 3'd5,
		op_sh  = 3'd6,
		op_sw  = 3'd7
	} lsu_op_e;

	// ------------------------------
	// sequencer states
	// ------------------------------
	typedef enum logic [2:0] {
		st_idle = 3'd0,
		st_addr = 3'd1,
		st_data = 3'd2,
		st_resp = 3'd3,
		st_done = 3'd4
	} lsu_state_e;

endpackage

/* logic/lsu_beat_plan.sv */
`timescale 1ns/1ps

module lsu_beat_plan #(
	parameter int ADDR_WIDTH = lsu_pkg::ADDR_WIDTH,
	parameter int BUS_WIDTH = lsu_pkg::BUS_WIDTH
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           accept,
	input  lsu_pkg::lsu_op_e               req_op,
	input  logic [ADDR_WIDTH-1:0]          req_addr,
	input  logic [lsu_pkg::DATA_WIDTH-1:0] req_wdata,
	input  logic                           second,
	output logic                           is_store,
	output logic                           need_second,
	output lsu_pkg::lsu_op_e               op,
	output logic [2:0]                     offset,
	output logic [ADDR_WIDTH-1:0]          awaddr,
	output logic [ADDR_WIDTH-1:0]          araddr,
	output logic [2:0]                     awsize,
	output logic [2:0]                     arsize,
	output logic [BUS_WIDTH/8-1:0]         wstrb,
	output logic [BUS_WIDTH-1:0]           wdata,
	output logic [BUS_WIDTH/8-1:0]         first_strb,
	output logic [BUS_WIDTH/8-1:0]         second_strb
);
	localparam int STRB_W = BUS_WIDTH / 8;
	localparam int LANE_BITS = $clog2(STRB_W);

	lsu_pkg::lsu_op_e op_q;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [lsu_pkg::DATA_WIDTH-1:0] wdata_q;
	logic [ADDR_WIDTH-1:0] second_addr;
	logic [3:0] byte_mask;
	logic [7:0] span;
	logic [2:0] size;
	logic [BUS_WIDTH-1:0] wdata_ext;
	logic [2*BUS_WIDTH-1:0] wdata_dbl;

	// ------------------------------
	// request capture
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			op_q <= lsu_pkg::op_lw;
		end else if (accept) begin
			op_q <= req_op;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			addr_q <= req_addr;
			wdata_q <= req_wdata;
		end
	end

	// ------------------------------
	// beat shape
	// ------------------------------
	always_comb begin
		case (op_q)
			lsu_pkg::op_lw, lsu_pkg::op_sw: begin
				byte_mask = 4'b1111;
				size = 3'd2;
			end
			lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: begin
				byte_mask = 4'b0011;
				size = 3'd1;
			end
			default: begin
				byte_mask = 4'b0001;
				size = 3'd0;
			end
		endcase
	end

	// bytes past bit 3 spill into the next 4-byte word
	assign span = {4'b0000, byte_mask} << addr_q[1:0];
	assign need_second = |span[7:4];
	assign is_store = op_q inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw};

	assign second_addr = {addr_q[ADDR_WIDTH-1:2], 2'b00} + ADDR_WIDTH'(4);
	assign first_strb = STRB_W'(span[3:0]) << {addr_q[LANE_BITS-1:2], 2'b00};
	assign second_strb = STRB_W'(span[7:4]) << second_addr[LANE_BITS-1:0];

	// store data rotated onto its lanes, one pattern serves both beats
	assign wdata_ext = BUS_WIDTH'(wdata_q);
	assign wdata_dbl = {wdata_ext, wdata_ext} << {addr_q[LANE_BITS-1:0], 3'b000};
	assign wdata = wdata_dbl[2*BUS_WIDTH-1 -: BUS_WIDTH];

	// ------------------------------
	// beat select
	// ------------------------------
	assign awaddr = second ? second_addr : addr_q;
	assign araddr = second ? second_addr : addr_q;
	assign wstrb = second ? second_strb : first_strb;
	assign awsize = size;
	assign arsize = size;
	assign op = op_q;
	assign offset = addr_q[2:0];

endmodule

/* logic/lsu_load_merge.sv */
`timescale 1ns/1ps

module lsu_load_merge #(
	parameter int BUS_WIDTH = lsu_pkg::BUS_WIDTH
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           first_capture,
	input  logic [BUS_WIDTH-1:0]           rdata,
	input  lsu_pkg::lsu_op_e               op,
	input  logic [2:0]                     offset,
	input  logic [BUS_WIDTH/8-1:0]         first_strb,
	input  logic [BUS_WIDTH/8-1:0]         second_strb,
	output logic [lsu_pkg::DATA_WIDTH-1:0] resp_rdata
);
	localparam int STRB_W = BUS_WIDTH / 8;

	logic [BUS_WIDTH-1:0] first_q;
	logic [BUS_WIDTH-1:0] last_q;
	logic [BUS_WIDTH-1:0] first_src;
	logic [3:0][7:0] word_bytes;
	logic [63:0] word_dbl;
	logic [31:0] aligned;

	// each read beat lands in last_q, the one before slides into first_q
	always_ff @(posedge clock) begin
		if (reset) begin
			first_q <= '0;
			last_q <= '0;
		end else if (first_capture) begin
			first_q <= last_q;
			last_q <= rdata;
		end
	end

	// ------------------------------
	// byte gather
	// ------------------------------
	// unsplit reads take all bytes from the only beat
	assign first_src = (|second_strb) ? first_q : last_q;

	always_comb begin
		word_bytes = '0;
		for (int j = 0; j < STRB_W; j++) begin
			if (first_strb[j]) begin
				word_bytes[j % 4] = word_bytes[j % 4] | first_src[8*j +: 8];
			end
			if (second_strb[j]) begin
				word_bytes[j % 4] = word_bytes[j % 4] | last_q[8*j +: 8];
			end
		end
	end

	// rotate so the byte at the access address sits in bits 7:0
	assign word_dbl = {word_bytes, word_bytes} >> {offset[1:0], 3'b000};
	assign aligned = word_dbl[31:0];

	// ------------------------------
	// extension
	// ------------------------------
	always_comb begin
		case (op)
			lsu_pkg::op_lb:  resp_rdata = {{(lsu_pkg::DATA_WIDTH-8){aligned[7]}}, aligned[7:0]};
			lsu_pkg::op_lbu: resp_rdata = {{(lsu_pkg::DATA_WIDTH-8){1'b0}}, aligned[7:0]};
			lsu_pkg::op_lh:  resp_rdata = {{(lsu_pkg::DATA_WIDTH-16){aligned[15]}}, aligned[15:0]};
			lsu_pkg::op_lhu: resp_rdata = {{(lsu_pkg::DATA_WIDTH-16){1'b0}}, aligned[15:0]};
			lsu_pkg::op_lw:  resp_rdata = aligned;
			// stores return no data
			default:         resp_rdata = '0;
		endcase
	end

endmodule

/* logic/lsu_fsm.sv */
`timescale 1ns/1ps

module lsu_fsm (
	input  logic       clock,
	input  logic       reset,
	input  logic       req_valid,
	input  logic       resp_ready,
	input  logic       is_store,
	input  logic       need_second,
	input  logic       awready,
	input  logic       wready,
	input  logic       bvalid,
	input  logic [1:0] bresp,
	input  logic       arready,
	input  logic       rvalid,
	input  logic [1:0] rresp,
	output logic       req_ready,
	output logic       accept,
	output logic       second,
	output logic       first_capture,
	output logic       resp_valid,
	output logic       resp_err,
	output logic       awvalid,
	output logic       wvalid,
	output logic       bready,
	output logic       arvalid,
	output logic       rready
);
	lsu_pkg::lsu_state_e state;
	logic err;
	logic b_fire;
	logic r_fire;
	logic beat_done;
	logic beat_err;

	// ------------------------------
	// channel controls
	// ------------------------------
	// idle with second set is the gap cycle between two beats
	assign req_ready = (state == lsu_pkg::st_idle) && !second;
	assign accept = req_valid && req_ready;

	assign awvalid = (state == lsu_pkg::st_addr) && is_store;
	assign arvalid = (state == lsu_pkg::st_addr) && !is_store;
	assign wvalid = (state == lsu_pkg::st_data);
	assign bready = (state == lsu_pkg::st_resp) && is_store;
	assign rready = (state == lsu_pkg::st_resp) && !is_store;

	assign resp_valid = (state == lsu_pkg::st_done);
	assign resp_err = err;

	assign b_fire = bvalid && bready;
	assign r_fire = rvalid && rready;
	assign beat_done = b_fire || r_fire;
	assign beat_err = (b_fire && (bresp != lsu_pkg::RESP_OKAY))
		|| (r_fire && (rresp != lsu_pkg::RESP_OKAY));

	// merger takes every read beat
	assign first_capture = r_fire;

	// ------------------------------
	// sequencing
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lsu_pkg::st_idle;
			second <= 1'b0;
			err <= 1'b0;
		end else begin
			// sticky across both beats of one access
			if (accept) begin
				err <= 1'b0;
			end else if (beat_err) begin
				err <= 1'b1;
			end

			case (state)
				lsu_pkg::st_idle: begin
					if (accept || second) begin
						state <= lsu_pkg::st_addr;
					end
				end
				lsu_pkg::st_addr: begin
					if (awvalid && awready) begin
						state <= lsu_pkg::st_data;
					end else if (arvalid && arready) begin
						state <= lsu_pkg::st_resp;
					end
				end
				lsu_pkg::st_data: begin
					if (wready) begin
						state <= lsu_pkg::st_resp;
					end
				end
				lsu_pkg::st_resp: begin
					if (beat_done) begin
						if (need_second && !second) begin
							second <= 1'b1;
							state <= lsu_pkg::st_idle;
						end else begin
							state <= lsu_pkg::st_done;
						end
					end
				end
				lsu_pkg::st_done: begin
					if (resp_ready) begin
						second <= 1'b0;
						state <= lsu_pkg::st_idle;
					end
				end
				default: begin
					state <= lsu_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
	parameter int ADDR_WIDTH = lsu_pkg::ADDR_WIDTH,
	parameter int BUS_WIDTH = lsu_pkg::BUS_WIDTH
) (
	input  logic                           clock,
	input  logic                           reset,
	// request
	input  logic                           req_valid,
	output logic                           req_ready,
	input  lsu_pkg::lsu_op_e               req_op,
	input  logic [ADDR_WIDTH-1:0]          req_addr,
	input  logic [lsu_pkg::DATA_WIDTH-1:0] req_wdata,
	// response
	output logic                           resp_valid,
	input  logic                           resp_ready,
	output logic [lsu_pkg::DATA_WIDTH-1:0] resp_rdata,
	output logic                           resp_err,
	// axi4-lite write
	output logic                           awvalid,
	input  logic                           awready,
	output logic [ADDR_WIDTH-1:0]          awaddr,
	output logic [2:0]                     awsize,
	output logic                           wvalid,
	input  logic                           wready,
	output logic [BUS_WIDTH-1:0]           wdata,
	output logic [BUS_WIDTH/8-1:0]         wstrb,
	input  logic                           bvalid,
	output logic                           bready,
	input  logic [1:0]                     bresp,
	// axi4-lite read
	output logic                           arvalid,
	input  logic                           arready,
	output logic [ADDR_WIDTH-1:0]          araddr,
	output logic [2:0]                     arsize,
	input  logic                           rvalid,
	output logic                           rready,
	input  logic [BUS_WIDTH-1:0]           rdata,
	input  logic [1:0]                     rresp
);
	logic accept;
	logic second;
	logic first_capture;
	logic is_store;
	logic need_second;
	lsu_pkg::lsu_op_e op;
	logic [2:0] offset;
	logic [BUS_WIDTH/8-1:0] first_strb;
	logic [BUS_WIDTH/8-1:0] second_strb;

	lsu_beat_plan #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.BUS_WIDTH(BUS_WIDTH)
	) u_beat_plan (
		.clock(clock), .reset(reset), .accept(accept),
		.req_op(req_op), .req_addr(req_addr), .req_wdata(req_wdata),
		.second(second), .is_store(is_store), .need_second(need_second),
		.op(op), .offset(offset), .awaddr(awaddr), .araddr(araddr),
		.awsize(awsize), .arsize(arsize), .wstrb(wstrb), .wdata(wdata),
		.first_strb(first_strb), .second_strb(second_strb)
	);

	lsu_load_merge #(
		.BUS_WIDTH(BUS_WIDTH)
	) u_load_merge (
		.clock(clock), .reset(reset), .first_capture(first_capture),
		.rdata(rdata), .op(op), .offset(offset), .first_strb(first_strb),
		.second_strb(second_strb), .resp_rdata(resp_rdata)
	);

	lsu_fsm u_fsm (
		.clock(clock), .reset(reset), .req_valid(req_valid),
		.resp_ready(resp_ready), .is_store(is_store), .need_second(need_second),
		.awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
		.arready(arready), .rvalid(rvalid), .rresp(rresp),
		.req_ready(req_ready), .accept(accept), .second(second),
		.first_capture(first_capture), .resp_valid(resp_valid), .resp_err(resp_err),
		.awvalid(awvalid), .wvalid(wvalid), .bready(bready),
		.arvalid(arvalid), .rready(rready)
	);

endmodule

/* test/lsu_props.sv */
`timescale 1ns/1ps

module lsu_props (
	input logic                clock,
	input logic                reset,
	input lsu_pkg::lsu_state_e state,
	input logic                second,
	input logic                req_ready,
	input logic                accept,
	input logic                awvalid,
	input logic                awready,
	input logic                wvalid,
	input logic                wready,
	input logic                arvalid,
	input logic                arready,
	input logic                resp_valid,
	input logic                resp_ready,
	input logic                resp_err
);
	// a raised valid waits for its ready
	aw_held: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");

	w_held: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid)
		else $error("wvalid dropped before wready");

	ar_held: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

	// beat address is picked by second
	addr_stable: assert property (@(posedge clock) disable iff (reset)
		(awvalid && !awready) || (arvalid && !arready) |=> $stable(second))
		else $error("beat address changed while its valid was waiting");

	resp_held: assert property (@(posedge clock) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_err))
		else $error("response dropped or changed before resp_ready");

	// busy from acceptance until the response handshake
	busy_not_ready: assert property (@(posedge clock) disable iff (reset)
		(accept || !req_ready) && !(resp_valid && resp_ready) |=> !req_ready)
		else $error("req_ready high while an access is in flight");

	// an accepted request raises its address valid at once
	accept_to_addr: assert property (@(posedge clock) disable iff (reset)
		accept |=> (state == lsu_pkg::st_addr) && (awvalid || arvalid))
		else $error("accepted request did not start its address phase");

endmodule

/* test/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;
	localparam int TIMEOUT = 200;
	localparam int RANDOM_RUNS = 300;
	localparam logic [1:0] SLVERR = 2'b10;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic req_valid = 1'b0;
	logic req_ready;
	lsu_pkg::lsu_op_e req_op = lsu_pkg::op_lw;
	logic [31:0] req_addr = '0;
	logic [31:0] req_wdata = '0;
	logic resp_valid;
	logic resp_ready = 1'b0;
	logic [31:0] resp_rdata;
	logic resp_err;
	logic awvalid;
	logic awready = 1'b0;
	logic [31:0] awaddr;
	logic [2:0] awsize;
	logic wvalid;
	logic wready = 1'b0;
	logic [63:0] wdata;
	logic [7:0] wstrb;
	logic bvalid = 1'b0;
	logic bready;
	logic [1:0] bresp = 2'b00;
	logic arvalid;
	logic arready = 1'b0;
	logic [31:0] araddr;
	logic [2:0] arsize;
	logic rvalid = 1'b0;
	logic rready;
	logic [63:0] rdata = '0;
	logic [1:0] rresp = 2'b00;

	// slave state and memories
	logic [7:0] mem [0:255];
	logic [7:0] ref_mem [0:255];
	logic [31:0] aw_addr_q = '0;
	logic [31:0] ar_addr_q = '0;
	logic [1:0] b_code = 2'b00;
	logic b_pending = 1'b0;
	logic r_pending = 1'b0;
	logic [31:0] slave_rand = '0;
	int aw_count = 0;
	int ar_count = 0;
	int seed;
	int error_count = 0;
	int timeout_count = 0;
	logic hung = 1'b0;

	// access in flight, for the slave's size checks
	string cur_name = "";
	logic [2:0] exp_size = '0;

	lsu_top #(.ADDR_WIDTH(32), .BUS_WIDTH(64)) UUT (.*);

	bind lsu_fsm lsu_props u_props (
		.clock(clock), .reset(reset), .state(state), .second(second),
		.req_ready(req_ready), .accept(accept), .awvalid(awvalid), .awready(awready),
		.wvalid(wvalid), .wready(wready), .arvalid(arvalid), .arready(arready),
		.resp_valid(resp_valid), .resp_ready(resp_ready), .resp_err(resp_err)
	);

	always #4 clock = ~clock;

	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	// ------------------------------
	// axi4-lite memory slave
	// ------------------------------
	task automatic write_beat(input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb);
		for (int j = 0; j < 8; j++) begin
			if (strb[j] && !addr[7]) begin
				mem[{addr[7:3], 3'(j)}] = data[8*j +: 8];
			end
		end
	endtask

	function automatic logic [63:0] read_beat(input logic [31:0] addr);
		logic [63:0] d;
		for (int j = 0; j < 8; j++) begin
			d[8*j +: 8] = mem[{addr[7:3], 3'(j)}];
		end
		return d;
	endfunction

	// slave ready and delay draws
	always @(negedge clock) begin
		slave_rand = rand32();
	end

	always @(posedge clock) begin
		logic [31:0] r;
		r = slave_rand;
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			b_pending <= 1'b0;
			r_pending <= 1'b0;
		end else begin
			awready <= r[0] | r[1];
			wready <= r[2] | r[3];
			arready <= r[4] | r[5];
			if (awvalid && awready) begin
				aw_addr_q <= awaddr;
				aw_count <= aw_count + 1;
				check_value({cur_name, " awsize"}, 32'(exp_size), 32'(awsize));
			end
			if (wvalid && wready) begin
				write_beat(aw_addr_q, wdata, wstrb);
				b_code <= aw_addr_q[7] ? SLVERR : lsu_pkg::RESP_OKAY;
				b_pending <= 1'b1;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end else if (b_pending && r[6]) begin
				bvalid <= 1'b1;
				bresp <= b_code;
				b_pending <= 1'b0;
			end
			if (arvalid && arready) begin
				ar_addr_q <= araddr;
				ar_count <= ar_count + 1;
				r_pending <= 1'b1;
				check_value({cur_name, " arsize"}, 32'(exp_size), 32'(arsize));
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end else if (r_pending && r[7]) begin
				rvalid <= 1'b1;
				rdata <= read_beat(ar_addr_q);
				rresp <= ar_addr_q[7] ? SLVERR : lsu_pkg::RESP_OKAY;
				r_pending <= 1'b0;
			end
		end
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic int access_bytes(input lsu_pkg::lsu_op_e op);
		case (op)
			lsu_pkg::op_lw, lsu_pkg::op_sw: return 4;
			lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return 2;
			default: return 1;
		endcase
	endfunction

	// bus size code from the access width
	function automatic logic [2:0] expected_size(input lsu_pkg::lsu_op_e op);
		case (access_bytes(op))
			4: return 3'd2;
			2: return 3'd1;
			default: return 3'd0;
		endcase
	endfunction

	// word splits off offset 0, half only at offset 3
	function automatic int expected_beats(input lsu_pkg::lsu_op_e op, input logic [31:0] addr);
		if (access_bytes(op) == 4) begin
			return (addr[1:0] != 2'd0) ? 2 : 1;
		end else if (access_bytes(op) == 2) begin
			return (addr[1:0] == 2'd3) ? 2 : 1;
		end
		return 1;
	endfunction

	// any byte in the upper half of the window faults
	function automatic logic model_err(input lsu_pkg::lsu_op_e op, input logic [31:0] addr);
		logic [31:0] a;
		logic err;
		err = 1'b0;
		for (int k = 0; k < access_bytes(op); k++) begin
			a = addr + 32'(k);
			err = err | a[7];
		end
		return err;
	endfunction

	function automatic logic [31:0] model_load(input lsu_pkg::lsu_op_e op,
			input logic [31:0] addr);
		logic [31:0] raw;
		logic [31:0] a;
		raw = '0;
		for (int k = 0; k < access_bytes(op); k++) begin
			a = addr + 32'(k);
			raw[8*k +: 8] = ref_mem[a[7:0]];
		end
		case (op)
			lsu_pkg::op_lb: return {{24{raw[7]}}, raw[7:0]};
			lsu_pkg::op_lh: return {{16{raw[15]}}, raw[15:0]};
			default: return raw;
		endcase
	endfunction

	task automatic model_store(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
			input logic [31:0] data);
		logic [31:0] a;
		for (int k = 0; k < access_bytes(op); k++) begin
			a = addr + 32'(k);
			if (!a[7]) begin
				ref_mem[a[7:0]] = data[8*k +: 8];
			end
		end
	endtask

	// ------------------------------
	// checks and requests
	// ------------------------------
	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic compare_memory(input string name);
		for (int i = 0; i < 256; i++) begin
			check_value($sformatf("%s mem[%02h]", name, i), 32'(ref_mem[i]), 32'(mem[i]));
		end
	endtask

	task automatic run_access(input string name, input lsu_pkg::lsu_op_e op,
			input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] r;
		logic [31:0] exp_data;
		logic exp_err;
		logic store;
		logic done;
		logic [31:0] got_data;
		logic got_err;
		int ar_start;
		int aw_start;
		int cycles;
		if (hung) begin
			return;
		end
		store = op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw};
		exp_data = model_load(op, addr);
		exp_err = model_err(op, addr);
		cur_name = name;
		exp_size = expected_size(op);
		@(posedge clock);
		ar_start = ar_count;
		aw_start = aw_count;
		req_valid <= 1'b1;
		req_op <= op;
		req_addr <= addr;
		req_wdata <= data;
		cycles = 0;
		do begin
			@(negedge clock);
			done = req_ready;
			@(posedge clock);
			cycles++;
		end while (!done && cycles < TIMEOUT);
		req_valid <= 1'b0;
		if (!done) begin
			$display("timeout: %s request at %h was never accepted", name, addr);
			timeout_count++;
			hung = 1'b1;
			return;
		end

		// random back-pressure on the response
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < TIMEOUT) begin
			r = rand32();
			resp_ready <= r[0] | r[1];
			@(negedge clock);
			if (resp_valid && resp_ready) begin
				done = 1'b1;
				got_data = resp_rdata;
				got_err = resp_err;
			end
			@(posedge clock);
			cycles++;
		end
		resp_ready <= 1'b0;
		if (!done) begin
			$display("timeout: %s access at %h never returned a response", name, addr);
			timeout_count++;
			hung = 1'b1;
			return;
		end

		check_value({name, " err"}, 32'(exp_err), 32'(got_err));
		if (!store && !exp_err) begin
			check_value({name, " data"}, exp_data, got_data);
		end
		check_value({name, " beats"}, 32'(expected_beats(op, addr)),
			32'(store ? aw_count - aw_start : ar_count - ar_start));
		if (store) begin
			model_store(op, addr, data);
		end
	endtask

	initial begin
		logic [31:0] r;
		seed = 32'h4d75;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 8'(i * 29 + 7);
			ref_mem[i] = 8'(i * 29 + 7);
		end
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("reset state", 32'h80,
			32'({req_ready, awvalid, wvalid, bready, arvalid, rready, resp_valid, resp_err}));

		// aligned store then load
		run_access("aligned sw", lsu_pkg::op_sw, 32'h10, 32'hcafe_1234);
		run_access("aligned lw", lsu_pkg::op_lw, 32'h10, 32'h0);
		run_access("aligned sh", lsu_pkg::op_sh, 32'h22, 32'h0000_beef);
		run_access("aligned lhu", lsu_pkg::op_lhu, 32'h22, 32'h0);
		run_access("aligned sb", lsu_pkg::op_sb, 32'h31, 32'h0000_005a);
		run_access("aligned lbu", lsu_pkg::op_lbu, 32'h31, 32'h0);

		// sign and zero extension
		run_access("sign sb", lsu_pkg::op_sb, 32'h41, 32'h0000_0085);
		run_access("sign lb", lsu_pkg::op_lb, 32'h41, 32'h0);
		run_access("sign lbu", lsu_pkg::op_lbu, 32'h41, 32'h0);
		run_access("sign sh", lsu_pkg::op_sh, 32'h44, 32'h0000_8001);
		run_access("sign lh", lsu_pkg::op_lh, 32'h44, 32'h0);
		run_access("sign lhu", lsu_pkg::op_lhu, 32'h44, 32'h0);

		// boundary crossing, also across the 8-byte lane wrap
		run_access("split sw", lsu_pkg::op_sw, 32'h53, 32'h8877_6655);
		run_access("split lw", lsu_pkg::op_lw, 32'h53, 32'h0);
		run_access("split sh", lsu_pkg::op_sh, 32'h5f, 32'h0000_a5c3);
		run_access("split lh", lsu_pkg::op_lh, 32'h5f, 32'h0);
		run_access("split lw wrap", lsu_pkg::op_lw, 32'h5e, 32'h0);

		// error window
		run_access("error sw", lsu_pkg::op_sw, 32'ha0, 32'h1111_2222);
		run_access("error lw", lsu_pkg::op_lw, 32'ha0, 32'h0);
		run_access("error split sw", lsu_pkg::op_sw, 32'h7e, 32'h3344_5566);
		compare_memory("error window");

		for (int i = 0; i < RANDOM_RUNS && !hung; i++) begin
			r = rand32();
			run_access("random", lsu_pkg::lsu_op_e'(r[2:0]),
				{24'h0, r[5:3] == 3'd0, r[14:8]}, rand32());
		end
		compare_memory("final");

		$display("run complete: %0d errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* tb.f */
logic/lsu_pkg.sv
logic/lsu_beat_plan.sv
logic/lsu_load_merge.sv
logic/lsu_fsm.sv
logic/lsu_top.sv
test/lsu_props.sv
test/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the lsu testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module lsu_tb -Mdir obj_dir -o lsu_sim; then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/lsu_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -qx "NO ERRORS" sim.log; then
	exit 0
fi
echo "simulation reported failures"
exit 1
